/* src/csr_pkg.sv */
package csr_pkg;

    localparam int IRQ_HW_W = 8;
    localparam int TIMER_W  = 32;   // default, widths 8..32 work

    typedef logic [13:0] csr_num_t;

    // supported csr numbers
    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    localparam logic [5:0] ECODE_INT = 6'h00;

    // request kind from the core
    typedef enum logic [2:0] {
        OP_NONE,
        OP_RD,
        OP_WR,
        OP_XCHG,
        OP_EXCP,
        OP_ERTN,
        OP_IDLE
    } csr_op_e;

    // what the unit does this cycle
    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_ACCESS,
        ACT_TRAP,
        ACT_ERTN
    } trap_act_e;

    typedef struct packed {
        csr_op_e     op;
        csr_num_t    num;
        logic [31:0] wdata;
        logic [31:0] mask;       // xchg only
        logic [31:0] pc;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
    } csr_req_t;

    typedef struct packed {
        logic        flush;
        logic [31:0] pc;
    } redirect_t;

endpackage

/* src/csr_timer.sv */
`timescale 1ns/10ps

module csr_timer #(
    parameter int TIMER_W = csr_pkg::TIMER_W
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               tcfg_we,
    input  logic               ticlr_we,
    input  logic [31:0]        wdata,
    output logic [TIMER_W-1:0] tcfg,
    output logic [TIMER_W-1:0] tval,
    output logic               ti
);

    logic               tcfg_new;   // tcfg written last cycle
    logic               en;
    logic               periodic;
    logic [TIMER_W-1:0] init_val;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign init_val = {tcfg[TIMER_W-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg     <= '0;
            tcfg_new <= 1'b0;
        end
        else
        begin
            tcfg_new <= tcfg_we;
            if (tcfg_we)
                tcfg <= wdata[TIMER_W-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            if (ticlr_we && wdata[0])
                ti <= 1'b0;
            else if (en && !tcfg_new && tval == '0)
                ti <= 1'b1;

            if (en && (tcfg_new || (periodic && tval == '0)))
                tval <= init_val;
            else if (en && tval != '1)
                tval <= tval - 1'b1;   // one-shot parks at all ones
        end
    end

endmodule

/* src/csr_regfile.sv */
`timescale 1ns/10ps

module csr_regfile import csr_pkg::*; #(
    parameter int TIMER_W = csr_pkg::TIMER_W
) (
    input  logic                clk,
    input  logic                rstn,
    input  csr_req_t            req,
    input  trap_act_e           act,
    input  logic [5:0]          trap_ecode,
    input  logic [8:0]          trap_esubcode,
    input  logic [31:0]         trap_era,
    input  logic [IRQ_HW_W-1:0] irq_hw,
    input  logic [TIMER_W-1:0]  tcfg,
    input  logic [TIMER_W-1:0]  tval,
    input  logic                ti,
    output logic [31:0]         rdata,
    output logic                int_pending,
    output logic [31:0]         eentry,
    output logic [31:0]         era,
    output logic [8:0]          crmd,
    output logic                tcfg_we,
    output logic                ticlr_we,
    output logic [31:0]         wdata
);

    logic [2:0]  prmd;
    logic [11:0] ecfg_lie;      // bit 10 stays zero
    logic [1:0]  estat_is;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:6] eentry_q;
    logic [31:0] save [4];
    logic [31:0] tid;
    logic [31:0] old_val;
    logic [31:0] wmask;
    logic [11:0] pending;
    logic        do_write;

    assign eentry  = {eentry_q, 6'b0};
    assign pending = {ti, 1'b0, irq_hw, estat_is};

    // interrupt seen only with global enable set
    assign int_pending = crmd[2] & |(pending & ecfg_lie);

    always_comb
    begin
        case (req.num)
            CSR_CRMD:   old_val = {23'b0, crmd};
            CSR_PRMD:   old_val = {29'b0, prmd};
            CSR_ECFG:   old_val = {20'b0, ecfg_lie};
            CSR_ESTAT:  old_val = {1'b0, estat_esubcode, estat_ecode, 4'b0, pending};
            CSR_ERA:    old_val = era;
            CSR_EENTRY: old_val = eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                old_val = save[req.num[1:0]];
            CSR_TID:    old_val = tid;
            CSR_TCFG:   old_val = 32'(tcfg);
            CSR_TVAL:   old_val = 32'(tval);
            default:    old_val = '0;   // ticlr and unknown numbers
        endcase
    end

    assign wmask    = (req.op == OP_WR) ? '1 : req.mask;
    assign wdata    = (old_val & ~wmask) | (req.wdata & wmask);
    assign do_write = (act == ACT_ACCESS) && (req.op != OP_RD);
    assign tcfg_we  = do_write && (req.num == CSR_TCFG);
    assign ticlr_we = do_write && (req.num == CSR_TICLR);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd           <= 9'h008;   // da=1
            prmd           <= '0;
            ecfg_lie       <= '0;
            estat_is       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            eentry_q       <= '0;
            save           <= '{default: '0};
            tid            <= '0;
        end
        else if (act == ACT_TRAP)
        begin
            prmd           <= crmd[2:0];
            crmd[2:0]      <= 3'b000;
            era            <= trap_era;
            estat_ecode    <= trap_ecode;
            estat_esubcode <= trap_esubcode;
        end
        else if (act == ACT_ERTN)
            crmd[2:0] <= prmd;
        else if (do_write)
        begin
            case (req.num)
                CSR_CRMD:
                begin
                    crmd[2:0] <= wdata[2:0];
                    crmd[8:5] <= wdata[8:5];
                    if (wdata[4] ^ wdata[3])   // da and pg exclusive
                        crmd[4:3] <= wdata[4:3];
                end
                CSR_PRMD:   prmd <= wdata[2:0];
                CSR_ECFG:   ecfg_lie <= {wdata[11], 1'b0, wdata[9:0]};
                CSR_ESTAT:  estat_is <= wdata[1:0];
                CSR_ERA:    era <= wdata;
                CSR_EENTRY: eentry_q <= wdata[31:6];
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                    save[req.num[1:0]] <= wdata;
                CSR_TID:    tid <= wdata;
                default:    ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            rdata <= '0;
        else
            rdata <= (act == ACT_ACCESS) ? old_val : '0;
    end

endmodule

/* src/trap_ctrl.sv */
`timescale 1ns/10ps

module trap_ctrl import csr_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  csr_req_t    req,
    input  logic        stall,
    input  logic        int_pending,
    input  logic [31:0] eentry,
    input  logic [31:0] era,
    output trap_act_e   act,
    output logic [5:0]  trap_ecode,
    output logic [8:0]  trap_esubcode,
    output logic [31:0] trap_era,
    output redirect_t   redirect,
    output logic        excp_flush,
    output logic        ertn_flush,
    output logic        clk_stall
);

    typedef enum logic {
        ST_RUN,
        ST_IDLE
    } state_e;

    state_e      state;
    state_e      state_nxt;
    logic        flush_nxt;
    logic [31:0] pc_nxt;
    logic        flush_q;
    logic [31:0] pc_q;

    // interrupt wins over stall and the held request
    always_comb
    begin
        act           = ACT_NONE;
        trap_ecode    = req.ecode;
        trap_esubcode = req.esubcode;
        trap_era      = req.pc;
        state_nxt     = state;
        if (int_pending)
        begin
            act           = ACT_TRAP;
            trap_ecode    = ECODE_INT;
            trap_esubcode = '0;
            state_nxt     = ST_RUN;
            if (state == ST_IDLE)
                trap_era = req.pc + 32'd4;   // resume past idle
        end
        else if (state == ST_RUN && !stall)
        begin
            case (req.op)
                OP_EXCP:               act = ACT_TRAP;
                OP_ERTN:               act = ACT_ERTN;
                OP_RD, OP_WR, OP_XCHG: act = ACT_ACCESS;
                OP_IDLE:               state_nxt = ST_IDLE;
                default:               ;
            endcase
        end
    end

    always_comb
    begin
        flush_nxt = 1'b1;
        pc_nxt    = req.pc + 32'd4;
        case (act)
            ACT_TRAP:   pc_nxt = eentry;
            ACT_ERTN:   pc_nxt = era;
            ACT_ACCESS: flush_nxt = (req.op != OP_RD);
            default:    flush_nxt = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state      <= ST_RUN;
            flush_q    <= 1'b0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            state      <= state_nxt;
            flush_q    <= flush_nxt;
            excp_flush <= (act == ACT_TRAP);
            ertn_flush <= (act == ACT_ERTN);
        end
    end

    always_ff @(posedge clk)
        pc_q <= pc_nxt;

    assign redirect  = '{flush: flush_q, pc: pc_q};
    assign clk_stall = (state == ST_IDLE);

endmodule

/* src/csr_unit.sv */
`timescale 1ns/10ps

module csr_unit import csr_pkg::*; #(
    parameter int TIMER_W = csr_pkg::TIMER_W
) (
    input  logic                clk,
    input  logic                rstn,
    input  csr_req_t            req,
    input  logic                stall,
    input  logic [IRQ_HW_W-1:0] irq_hw,
    output logic [31:0]         rdata,
    output redirect_t           redirect,
    output logic                excp_flush,
    output logic                ertn_flush,
    output logic [8:0]          crmd,
    output logic                clk_stall
);

    trap_act_e          act;
    logic [5:0]         trap_ecode;
    logic [8:0]         trap_esubcode;
    logic [31:0]        trap_era;
    logic               int_pending;
    logic [31:0]        eentry;
    logic [31:0]        era;
    logic               tcfg_we;
    logic               ticlr_we;
    logic [31:0]        wdata;
    logic [TIMER_W-1:0] tcfg;
    logic [TIMER_W-1:0] tval;
    logic               ti;

    trap_ctrl trap_ctrl_i (
        .clk, .rstn, .req, .stall, .int_pending, .eentry, .era,
        .act, .trap_ecode, .trap_esubcode, .trap_era,
        .redirect, .excp_flush, .ertn_flush, .clk_stall
    );

    csr_regfile #(.TIMER_W(TIMER_W)) csr_regfile_i (
        .clk, .rstn, .req, .act, .trap_ecode, .trap_esubcode, .trap_era,
        .irq_hw, .tcfg, .tval, .ti,
        .rdata, .int_pending, .eentry, .era, .crmd,
        .tcfg_we, .ticlr_we, .wdata
    );

    csr_timer #(.TIMER_W(TIMER_W)) csr_timer_i (
        .clk, .rstn, .tcfg_we, .ticlr_we, .wdata,
        .tcfg, .tval, .ti
    );

endmodule

/* testbench/csr_model.svh */
logic [31:0] model_csr [0:16383];   // one slot per csr number
int          errors;
int          timeouts;

function automatic logic [31:0] writable_bits(input csr_num_t num);
    case (num)
        CSR_CRMD:   return 32'h0000_01ff;
        CSR_EENTRY: return 32'hffff_ffc0;   // 64-byte aligned entry
        default:    return 32'hffff_ffff;
    endcase
endfunction

function automatic logic [31:0] merge_value(input csr_op_e op, input logic [31:0] wdata,
                                           input logic [31:0] mask, input logic [31:0] old);
    logic [31:0] merged;
    merged = old;
    for (int i = 0; i < 32; i++)
        if (op == OP_WR || mask[i])
            merged[i] = wdata[i];   // new bit wherever it is selected
    return merged;
endfunction

task automatic store_csr(input csr_num_t num, input logic [31:0] value);
    model_csr[num] = value & writable_bits(num);
endtask

// plv and ie move to prmd
task automatic enter_trap(input logic [31:0] era, input logic [5:0] ecode,
                          input logic [8:0] esub);
    model_csr[CSR_PRMD]  = model_csr[CSR_CRMD] & 32'h7;
    model_csr[CSR_CRMD]  = model_csr[CSR_CRMD] & ~32'h7;
    model_csr[CSR_ERA]   = era;
    model_csr[CSR_ESTAT] = {1'b0, esub, ecode, 16'h0};   // no pending lines assumed
endtask

task automatic leave_trap();
    model_csr[CSR_CRMD] = (model_csr[CSR_CRMD] & ~32'h7) | model_csr[CSR_PRMD];
endtask

task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
    $display("Fail %s: expected %0h, got %0h", name, exp, got);
    errors++;
endtask

task automatic check_rdata(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp)
        mismatch(name, 64'(exp), 64'(got));
endtask

task automatic check_redirect(input string name, input redirect_t exp, input redirect_t got);
    if (got !== exp)
        mismatch(name, 64'(exp), 64'(got));
endtask

task automatic check_crmd(input string name, input logic [8:0] exp, input logic [8:0] got);
    if (got !== exp)
        mismatch(name, 64'(exp), 64'(got));
endtask

task automatic check_flag(input string name, input logic exp, input logic got);
    if (got !== exp)
        mismatch(name, 64'(exp), 64'(got));
endtask

/* testbench/csr_unit_tb.sv */
`timescale 1ns/10ps

module csr_unit_tb import csr_pkg::*; ();

    logic                clk;
    logic                rstn;
    logic                stall;
    csr_req_t            req;
    logic [IRQ_HW_W-1:0] irq_hw;
    logic [31:0]         rdata;
    redirect_t           redirect;
    logic                excp_flush;
    logic                ertn_flush;
    logic [8:0]          crmd;
    logic                clk_stall;
    integer              seed;

    `include "csr_model.svh"

    csr_unit #(.TIMER_W(TIMER_W)) csr_unit_i (
        .clk, .rstn, .req, .stall, .irq_hw,
        .rdata, .redirect, .excp_flush, .ertn_flush, .crmd, .clk_stall
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic load_req(input csr_op_e op, input csr_num_t num, input logic [31:0] wdata,
                            input logic [31:0] mask);
        req          = '0;
        req.op       = op;
        req.num      = num;
        req.wdata    = wdata;
        req.mask     = mask;
        req.pc       = $random(seed) & 32'hffff_fffc;
        req.ecode    = 6'($random(seed));
        req.esubcode = 9'($random(seed));
    endtask

    // outputs of the consumed request valid on return
    task automatic send_req(input csr_op_e op, input csr_num_t num, input logic [31:0] wdata,
                            input logic [31:0] mask);
        load_req(op, num, wdata, mask);
        tick();
        req.op = OP_NONE;
    endtask

    task automatic write_csr(input csr_num_t num, input logic [31:0] value);
        send_req(OP_WR, num, value, '0);
        store_csr(num, value);
    endtask

    function automatic redirect_t redirect_of(input logic flush, input logic [31:0] pc);
        redirect_t r;
        r.flush = flush;
        r.pc    = pc;
        return r;
    endfunction

    function automatic csr_num_t pick_num(input int idx);
        case (idx)
            4:       return CSR_TID;
            5:       return CSR_EENTRY;
            6:       return CSR_ERA;
            default: return CSR_SAVE0 + csr_num_t'(idx);
        endcase
    endfunction

    task automatic wait_excp_flush(input int limit, input string what);
        int n;
        n = 0;
        while (!excp_flush && n < limit)
        begin
            tick();
            n++;
        end
        if (!excp_flush)
        begin
            $display("timeout while waiting for the %s", what);
            timeouts++;
        end
    endtask

    initial
    begin
        int          n;
        csr_num_t    num;
        csr_op_e     op;
        logic [31:0] wd;
        logic [31:0] mk;
        logic [31:0] old;
        logic [31:0] pc;

        seed     = 54;
        errors   = 0;
        timeouts = 0;
        rstn     = 1'b0;
        stall    = 1'b0;
        irq_hw   = '0;
        req      = '0;
        for (int i = 0; i < 16384; i++)
            model_csr[csr_num_t'(i)] = '0;
        store_csr(CSR_CRMD, 32'h8);
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        check_crmd("crmd", model_csr[CSR_CRMD][8:0], crmd);
        check_flag("clk_stall", 1'b0, clk_stall);

        for (int i = 0; i < 24; i++)
        begin
            num = pick_num($unsigned($random(seed)) % 7);
            op  = ($random(seed) & 1) ? OP_XCHG : OP_WR;
            wd  = $random(seed);
            mk  = $random(seed);
            old = model_csr[num];
            send_req(op, num, wd, mk);
            check_rdata("rdata", old, rdata);   // old value back
            check_redirect("redirect", redirect_of(1'b1, req.pc + 32'd4), redirect);
            store_csr(num, merge_value(op, wd, mk, old));
            send_req(OP_RD, num, '0, '0);
            check_rdata("rdata", model_csr[num], rdata);
            check_flag("redirect.flush", 1'b0, redirect.flush);
        end

        // exception entry with random plv and ie
        write_csr(CSR_CRMD, 32'h8 | 32'($random(seed) & 7));
        check_crmd("crmd", model_csr[CSR_CRMD][8:0], crmd);
        send_req(OP_EXCP, CSR_ERA, '0, '0);
        check_redirect("redirect", redirect_of(1'b1, model_csr[CSR_EENTRY]), redirect);
        check_flag("excp_flush", 1'b1, excp_flush);
        enter_trap(req.pc, req.ecode, req.esubcode);
        tick();
        check_flag("excp_flush", 1'b0, excp_flush);
        send_req(OP_RD, CSR_ERA, '0, '0);
        check_rdata("rdata", model_csr[CSR_ERA], rdata);
        send_req(OP_RD, CSR_PRMD, '0, '0);
        check_rdata("rdata", model_csr[CSR_PRMD], rdata);
        send_req(OP_RD, CSR_ESTAT, '0, '0);
        check_rdata("rdata", model_csr[CSR_ESTAT], rdata);
        check_crmd("crmd", model_csr[CSR_CRMD][8:0], crmd);

        send_req(OP_ERTN, CSR_ERA, '0, '0);
        check_redirect("redirect", redirect_of(1'b1, model_csr[CSR_ERA]), redirect);
        check_flag("ertn_flush", 1'b1, ertn_flush);
        leave_trap();
        check_crmd("crmd", model_csr[CSR_CRMD][8:0], crmd);
        tick();
        check_flag("ertn_flush", 1'b0, ertn_flush);

        // one-shot timer interrupt from 16
        write_csr(CSR_ECFG, 32'h800);
        write_csr(CSR_CRMD, 32'h00c);
        write_csr(CSR_TCFG, 32'h11);
        wait_excp_flush(200, "timer interrupt");
        check_redirect("redirect", redirect_of(1'b1, model_csr[CSR_EENTRY]), redirect);
        enter_trap(req.pc, ECODE_INT, '0);
        send_req(OP_RD, CSR_ESTAT, '0, '0);
        check_rdata("rdata[21:16]", 32'h0, 32'(rdata[21:16]));
        check_flag("rdata[11]", 1'b1, rdata[11]);
        write_csr(CSR_TICLR, 32'h1);
        send_req(OP_RD, CSR_ESTAT, '0, '0);
        check_flag("rdata[11]", 1'b0, rdata[11]);

        // request held under stall
        num = pick_num($unsigned($random(seed)) % 4);
        op  = ($random(seed) & 1) ? OP_XCHG : OP_WR;
        wd  = $random(seed);
        mk  = $random(seed);
        old = model_csr[num];
        stall = 1'b1;
        load_req(op, num, wd, mk);
        n = 1 + ($unsigned($random(seed)) % 4);
        repeat (n)
        begin
            tick();
            check_flag("redirect.flush", 1'b0, redirect.flush);
        end
        stall = 1'b0;
        tick();
        req.op = OP_NONE;
        check_rdata("rdata", old, rdata);
        check_flag("redirect.flush", 1'b1, redirect.flush);
        store_csr(num, merge_value(op, wd, mk, old));

        // idle until irq_hw[0]
        write_csr(CSR_ECFG, 32'h4);
        write_csr(CSR_CRMD, 32'h00c);
        send_req(OP_IDLE, CSR_CRMD, '0, '0);
        pc = req.pc;
        check_flag("clk_stall", 1'b1, clk_stall);
        repeat (3)
        begin
            tick();
            check_flag("clk_stall", 1'b1, clk_stall);
        end
        irq_hw = 8'h01;
        wait_excp_flush(20, "idle wakeup");
        irq_hw = '0;
        check_flag("clk_stall", 1'b0, clk_stall);
        check_redirect("redirect", redirect_of(1'b1, model_csr[CSR_EENTRY]), redirect);
        enter_trap(pc + 32'd4, ECODE_INT, '0);
        send_req(OP_RD, CSR_ERA, '0, '0);
        check_rdata("rdata", model_csr[CSR_ERA], rdata);

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* compile.f */
+incdir+testbench
src/csr_pkg.sv
src/csr_timer.sv
src/csr_regfile.sv
src/trap_ctrl.sv
src/csr_unit.sv
testbench/csr_unit_tb.sv
